/* dv/flash_ctrl_assert.sv */
`timescale 1ns/1ps

module flash_ctrl_assert (
	input logic clk,
	input logic reset_n,
	input logic cs_n,
	input logic sclk,
	input logic flash_ack,
	input logic valid,
	input logic data_take
);

	int fail_cnt = 0;

	ack_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		flash_ack |=> !flash_ack)
		else begin
			fail_cnt++;
			$error("flash_ack stayed high for more than one cycle");
		end

	ack_cs_high: assert property (@(posedge clk) disable iff (!reset_n)
		flash_ack |-> cs_n)
		else begin
			fail_cnt++;
			$error("flash_ack came while chip select was still low");
		end

	// mode 0 idles the clock low
	sclk_idle: assert property (@(posedge clk) disable iff (!reset_n)
		cs_n |-> !sclk)
		else begin
			fail_cnt++;
			$error("sclk was high while chip select was high");
		end

	valid_in_frame: assert property (@(posedge clk) disable iff (!reset_n)
		valid |-> !cs_n)
		else begin
			fail_cnt++;
			$error("valid pulsed outside a chip select frame");
		end

	take_in_frame: assert property (@(posedge clk) disable iff (!reset_n)
		data_take |-> !cs_n)
		else begin
			fail_cnt++;
			$error("data_take pulsed outside a chip select frame");
		end

endmodule

bind flash_ctrl flash_ctrl_assert flash_ctrl_assert_i (
	.clk(clk),
	.reset_n(reset_n),
	.cs_n(cs_n),
	.sclk(sclk),
	.flash_ack(flash_ack),
	.valid(valid),
	.data_take(data_take)
);

/* dv/flash_ctrl_tb.sv */
`timescale 1ns/1ps

module flash_ctrl_tb;

	localparam int xfer_bytes = 16;
	localparam int cs_gap     = 4;
	localparam int max_cycles = 20000; // six jobs of at most about 600 cycles each leave a wide margin

	logic        clk;
	logic        reset_n;
	logic        rd_req, pp_req, se_req;
	logic [23:0] rd_addr, wr_addr, se_addr;
	logic [7:0]  wr_data;
	logic        flash_ack, valid, data_take;
	logic [31:0] rdata;
	logic        sclk, cs_n, mosi, miso;
	logic        flash_busy, refused;

	logic [7:0]  shadow [0:4095];
	logic [7:0]  page [0:xfer_bytes-1];
	logic [11:0] rd_base;
	logic        started;
	int          word_cnt, take_cnt, exp_words, exp_takes;
	int          errors, cycles;
	integer      seed;

	flash_ctrl #(
		.xfer_bytes(xfer_bytes),
		.cs_gap(cs_gap)
	) flash_ctrl_i (.*);

	spi_flash_model flash_i (
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.busy(flash_busy),
		.refused(refused)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("timeout: the job sequence did not finish within %0d cycles", max_cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (valid) begin
			word_cnt <= word_cnt + 1;
		end
		if (data_take) begin
			take_cnt <= take_cnt + 1;
			wr_data  <= page[(take_cnt + 1) % xfer_bytes]; // ready before the next byte_start
		end
	end

	// little-endian word from the shadow copy
	function automatic logic [31:0] shadow_word(input logic [11:0] a);
		return {shadow[a + 12'd3], shadow[a + 12'd2], shadow[a + 12'd1], shadow[a]};
	endfunction

	assert property (@(posedge clk) disable iff (!reset_n)
		!started |-> cs_n && !sclk && !mosi && !flash_ack && !valid && !data_take)
		else begin
			errors++;
			$display("error: cs_n %h sclk %h mosi %h flash_ack %h valid %h data_take %h at idle",
				$sampled(cs_n), $sampled(sclk), $sampled(mosi), $sampled(flash_ack),
				$sampled(valid), $sampled(data_take));
		end

	assert property (@(posedge clk) disable iff (!reset_n)
		valid |-> rdata == shadow_word(rd_base + 12'(4 * word_cnt)))
		else begin
			errors++;
			$display("error: rdata %h expected %h", $sampled(rdata),
				shadow_word(rd_base + 12'(4 * $sampled(word_cnt))));
		end

	assert property (@(posedge clk) disable iff (!reset_n) flash_ack |-> word_cnt == exp_words)
		else begin
			errors++;
			$display("error: valid count %h expected %h", $sampled(word_cnt), exp_words);
		end

	assert property (@(posedge clk) disable iff (!reset_n) flash_ack |-> take_cnt == exp_takes)
		else begin
			errors++;
			$display("error: data_take count %h expected %h", $sampled(take_cnt), exp_takes);
		end

	assert property (@(posedge clk) disable iff (!reset_n) !refused)
		else begin
			errors++;
			$display("the flash refused a program or erase that had no write enable before it");
		end

	assert property (@(posedge clk) disable iff (!reset_n) flash_ack |-> !flash_busy)
		else begin
			errors++;
			$display("flash_ack came while the flash was still busy writing");
		end

	assert property (@(posedge clk) disable iff (!reset_n) $fell(flash_busy) |-> ##[1:64] flash_ack)
		else begin
			errors++;
			$display("no flash_ack followed the end of the flash busy time");
		end

	task automatic fill_page();
		for (int i = 0; i < xfer_bytes; i++) begin
			page[i] = 8'($random(seed));
		end
	endtask

	task automatic do_job(input flash_pkg::flash_job_e job, input logic [23:0] addr);
		@(posedge clk);
		started   <= 1'b1;
		word_cnt  <= 0;
		take_cnt  <= 0;
		exp_words <= (job == flash_pkg::job_read) ? xfer_bytes / 4 : 0;
		exp_takes <= (job == flash_pkg::job_pp) ? xfer_bytes : 0;
		rd_base   <= addr[11:0];
		wr_data   <= page[0];
		case (job)
			flash_pkg::job_read: begin
				rd_addr <= addr;
				rd_req  <= 1'b1;
			end
			flash_pkg::job_pp: begin
				wr_addr <= addr;
				pp_req  <= 1'b1;
			end
			default: begin
				se_addr <= addr;
				se_req  <= 1'b1;
			end
		endcase
		@(posedge clk);
		while (!flash_ack) begin
			@(posedge clk);
		end
		rd_req <= 1'b0;
		pp_req <= 1'b0;
		se_req <= 1'b0;
		if (job == flash_pkg::job_pp) begin
			for (int i = 0; i < xfer_bytes; i++) begin
				shadow[addr[11:0] + 12'(i)] = shadow[addr[11:0] + 12'(i)] & page[i]; // bits only clear
			end
		end else if (job == flash_pkg::job_se) begin
			for (int i = 0; i < 4096; i++) begin
				shadow[i] = 8'hff;
			end
		end
	endtask

	initial begin
		seed      = 32'h122d;
		reset_n   = 1'b0;
		rd_req    = 1'b0;
		pp_req    = 1'b0;
		se_req    = 1'b0;
		rd_addr   = '0;
		wr_addr   = '0;
		se_addr   = '0;
		wr_data   = '0;
		rd_base   = '0;
		started   = 1'b0;
		word_cnt  = 0;
		take_cnt  = 0;
		exp_words = 0;
		exp_takes = 0;
		errors    = 0;
		cycles    = 0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		repeat (8) @(posedge clk);
		do_job(flash_pkg::job_se, 24'h000000);
		do_job(flash_pkg::job_read, 24'h000100);
		fill_page();
		do_job(flash_pkg::job_pp, 24'h000100);
		do_job(flash_pkg::job_read, 24'h000100);
		fill_page();
		do_job(flash_pkg::job_pp, 24'h000108); // overlaps the upper half of the first page
		do_job(flash_pkg::job_read, 24'h000108);
		repeat (8) @(posedge clk);
		$display("errors: %0d testbench checks, %0d protocol checks", errors,
			flash_ctrl_i.flash_ctrl_assert_i.fail_cnt);
		if (errors == 0 && flash_ctrl_i.flash_ctrl_assert_i.fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* dv/spi_flash_model.sv */
`timescale 1ns/1ps

module spi_flash_model #(
	parameter int mem_bytes = 4096,
	parameter int pp_polls  = 5,
	parameter int se_polls  = 12
) (
	input  logic sclk,
	input  logic cs_n,
	input  logic mosi,
	output logic miso,
	output logic busy,
	output logic refused
);

	localparam int sector_bytes = 4096;

	logic [7:0]                mem [0:mem_bytes-1];
	logic [7:0]                rx_bytes [0:263]; // opcode, address and up to one page
	logic [7:0]                in_sh;
	logic [7:0]                out_byte;
	logic [23:0]               addr;
	logic                      wel = 1'b0;
	int                        rise_cnt = 0;
	int                        busy_polls = 0;
	flash_pkg::flash_rx_byte_u sts;

	assign busy = (busy_polls != 0);
	assign addr = {rx_bytes[1], rx_bytes[2], rx_bytes[3]};

	initial begin
		miso    = 1'b0;
		refused = 1'b0;
		for (int i = 0; i < mem_bytes; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a; // power-up content that differs from the erased state
		end
	end

	always @(negedge cs_n) begin
		rise_cnt    = 0;
		rx_bytes[0] = 8'h00;
		miso        = 1'b0;
	end

	// mode 0 so mosi is taken on the rising edge
	always @(posedge sclk) begin
		if (!cs_n) begin
			in_sh = {in_sh[6:0], mosi};
			rise_cnt++;
			if (rise_cnt % 8 == 0 && rise_cnt / 8 <= 264) begin
				rx_bytes[rise_cnt / 8 - 1] = in_sh;
			end
		end
	end

	always @(negedge sclk) begin
		if (!cs_n) begin
			if (rise_cnt % 8 == 0) begin
				out_byte = 8'h00;
				if (rx_bytes[0] == flash_pkg::op_read && rise_cnt >= 32) begin
					out_byte = mem[(addr + rise_cnt / 8 - 4) % mem_bytes];
				end else if (rx_bytes[0] == flash_pkg::op_rdsr) begin
					sts.status = '{reserved: 6'd0, wel: wel, wip: (busy_polls != 0)};
					out_byte   = sts.raw;
					if (busy_polls != 0) begin
						busy_polls--; // each status byte sent counts as one poll
					end
				end
			end
			miso = out_byte[7 - rise_cnt % 8];
		end
	end

	// writes take effect when chip select rises
	always @(posedge cs_n) begin
		int base;
		if (rise_cnt >= 8) begin
			case (rx_bytes[0])
				flash_pkg::op_wren: begin
					wel = 1'b1;
				end
				flash_pkg::op_pp: begin
					if (!wel) begin
						refused = 1'b1;
					end else begin
						for (int i = 4; i < rise_cnt / 8; i++) begin
							mem[(addr + i - 4) % mem_bytes] &= rx_bytes[i];
						end
						wel        = 1'b0;
						busy_polls = pp_polls;
					end
				end
				flash_pkg::op_se: begin
					if (!wel) begin
						refused = 1'b1;
					end else begin
						base = (addr % mem_bytes) & ~(sector_bytes - 1);
						for (int i = 0; i < sector_bytes; i++) begin
							mem[(base + i) % mem_bytes] = 8'hff;
						end
						wel        = 1'b0;
						busy_polls = se_polls;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* list.f */
logic/flash_pkg.sv
logic/flash_seq_fsm.sv
logic/flash_byte_timer.sv
logic/flash_tx_mux.sv
logic/flash_rx_pack.sv
logic/spi_byte_shifter.sv
logic/flash_ctrl.sv
dv/spi_flash_model.sv
dv/flash_ctrl_assert.sv
dv/flash_ctrl_tb.sv

/* logic/flash_byte_timer.sv */
`timescale 1ns/1ps

module flash_byte_timer #(
	parameter int cs_gap = 4
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  flash_pkg::flash_phase_e phase,
	input  logic                    byte_done,
	input  logic                    gap_start,
	output logic [8:0]              byte_idx,
	output logic                    gap_done
);

	localparam int gap_w = $clog2(cs_gap + 1);

	flash_pkg::flash_phase_e phase_q;
	logic [gap_w-1:0]        gap_cnt;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			phase_q  <= flash_pkg::ph_idle;
			byte_idx <= '0;
		end else begin
			phase_q <= phase;
			if (phase != phase_q) begin
				byte_idx <= '0; // each command counts its bytes from zero
			end else if (byte_done) begin
				byte_idx <= byte_idx + 9'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			gap_cnt  <= '0;
			gap_done <= 1'b0;
		end else begin
			gap_done <= (gap_cnt == gap_w'(1)) && !gap_start;
			if (gap_start) begin
				gap_cnt <= gap_w'(cs_gap - 1);
			end else if (gap_cnt != '0) begin
				gap_cnt <= gap_cnt - 1'b1;
			end
		end
	end

endmodule

/* logic/flash_ctrl.sv */
`timescale 1ns/1ps

module flash_ctrl #(
	parameter int xfer_bytes = 16,
	parameter int cs_gap     = 4
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        rd_req,
	input  logic        pp_req,
	input  logic        se_req,
	input  logic [23:0] rd_addr,
	input  logic [23:0] wr_addr,
	input  logic [23:0] se_addr,
	input  logic [7:0]  wr_data,
	output logic        flash_ack,
	output logic [31:0] rdata,
	output logic        valid,
	output logic        data_take,
	output logic        sclk,
	output logic        cs_n,
	output logic        mosi,
	input  logic        miso
);

	flash_pkg::flash_cmd_t    cmd;
	flash_pkg::flash_phase_e  phase;
	flash_pkg::flash_status_t status;
	logic                     byte_start;
	logic                     byte_done;
	logic                     gap_start;
	logic                     gap_done;
	logic [8:0]               byte_idx;
	logic [7:0]               tx_byte;
	logic [7:0]               rx_byte;

	flash_seq_fsm #(
		.xfer_bytes(xfer_bytes)
	) seq_fsm_i (
		.clk(clk),
		.reset_n(reset_n),
		.rd_req(rd_req),
		.pp_req(pp_req),
		.se_req(se_req),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.se_addr(se_addr),
		.byte_done(byte_done),
		.byte_idx(byte_idx),
		.gap_done(gap_done),
		.status(status),
		.cmd(cmd),
		.phase(phase),
		.byte_start(byte_start),
		.gap_start(gap_start),
		.cs_n(cs_n),
		.flash_ack(flash_ack),
		.data_take(data_take)
	);

	flash_byte_timer #(
		.cs_gap(cs_gap)
	) byte_timer_i (
		.clk(clk),
		.reset_n(reset_n),
		.phase(phase),
		.byte_done(byte_done),
		.gap_start(gap_start),
		.byte_idx(byte_idx),
		.gap_done(gap_done)
	);

	flash_tx_mux tx_mux_i (
		.cmd(cmd),
		.phase(phase),
		.byte_idx(byte_idx),
		.wr_data(wr_data),
		.tx_byte(tx_byte)
	);

	flash_rx_pack rx_pack_i (
		.clk(clk),
		.reset_n(reset_n),
		.phase(phase),
		.cmd(cmd),
		.byte_idx(byte_idx),
		.byte_done(byte_done),
		.rx_byte(rx_byte),
		.rdata(rdata),
		.valid(valid),
		.status(status)
	);

	spi_byte_shifter shifter_i (
		.clk(clk),
		.reset_n(reset_n),
		.byte_start(byte_start),
		.tx_byte(tx_byte),
		.miso(miso),
		.byte_done(byte_done),
		.rx_byte(rx_byte),
		.sclk(sclk),
		.mosi(mosi)
	);

endmodule

/* logic/flash_pkg.sv */
package flash_pkg;

	localparam logic [7:0] op_read = 8'h03;
	localparam logic [7:0] op_wren = 8'h06;
	localparam logic [7:0] op_pp   = 8'h02;
	localparam logic [7:0] op_se   = 8'hd8;
	localparam logic [7:0] op_rdsr = 8'h05;

	typedef enum logic [1:0] {
		job_none,
		job_read,
		job_pp,
		job_se
	} flash_job_e;

	// one job as latched from the host requests
	typedef struct packed {
		flash_job_e  job;
		logic [23:0] addr;
	} flash_cmd_t;

	// command currently framed by chip select
	typedef enum logic [2:0] {
		ph_idle,
		ph_wren,
		ph_main,
		ph_poll
	} flash_phase_e;

	typedef struct packed {
		logic [5:0] reserved;
		logic       wel;      // write enable latch
		logic       wip;      // write in progress
	} flash_status_t;

	// a received byte is array data during a read and the status register while polling
	typedef union packed {
		logic [7:0]    raw;
		flash_status_t status;
	} flash_rx_byte_u;

endpackage

/* logic/flash_rx_pack.sv */
`timescale 1ns/1ps

module flash_rx_pack (
	input  logic                     clk,
	input  logic                     reset_n,
	input  flash_pkg::flash_phase_e  phase,
	input  flash_pkg::flash_cmd_t    cmd,
	input  logic [8:0]               byte_idx,
	input  logic                     byte_done,
	input  flash_pkg::flash_rx_byte_u rx_byte,
	output logic [31:0]              rdata,
	output logic                     valid,
	output flash_pkg::flash_status_t status
);

	logic data_byte;
	logic [1:0] lane;

	assign data_byte = byte_done && (phase == flash_pkg::ph_main) &&
		(cmd.job == flash_pkg::job_read) && (byte_idx >= 9'd4);

	// data starts at index 4, so the low index bits already give the byte lane
	assign lane = byte_idx[1:0];

	always_ff @(posedge clk) begin
		if (data_byte) begin
			rdata[lane*8 +: 8] <= rx_byte.raw; // first byte lands in the low lane
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			valid  <= 1'b0;
			status <= '0;
		end else begin
			valid <= data_byte && (lane == 2'd3);
			if (byte_done && phase == flash_pkg::ph_poll && byte_idx != 9'd0) begin
				status <= rx_byte.status;
			end
		end
	end

endmodule

/* logic/flash_seq_fsm.sv */
`timescale 1ns/1ps

module flash_seq_fsm #(
	parameter int xfer_bytes = 16
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    rd_req,
	input  logic                    pp_req,
	input  logic                    se_req,
	input  logic [23:0]             rd_addr,
	input  logic [23:0]             wr_addr,
	input  logic [23:0]             se_addr,
	input  logic                    byte_done,
	input  logic [8:0]              byte_idx,
	input  logic                    gap_done,
	input  flash_pkg::flash_status_t status,
	output flash_pkg::flash_cmd_t   cmd,
	output flash_pkg::flash_phase_e phase,
	output logic                    byte_start,
	output logic                    gap_start,
	output logic                    cs_n,
	output logic                    flash_ack,
	output logic                    data_take
);

	typedef enum logic [2:0] {
		st_idle,
		st_open,
		st_xfer,
		st_next,
		st_gap,
		st_close,
		st_ack
	} state_e;

	localparam logic [8:0] rw_len = 9'(4 + xfer_bytes); // opcode, three address bytes, data

	state_e     state;
	logic [8:0] main_len;

	assign main_len = (cmd.job == flash_pkg::job_se) ? 9'd4 : rw_len;

	// host data bytes follow the opcode and the address
	assign data_take = byte_done && (phase == flash_pkg::ph_main) &&
		(cmd.job == flash_pkg::job_pp) && (byte_idx >= 9'd4);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state      <= st_idle;
			phase      <= flash_pkg::ph_idle;
			cmd        <= '0;
			byte_start <= 1'b0;
			gap_start  <= 1'b0;
			cs_n       <= 1'b1;
			flash_ack  <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			gap_start  <= 1'b0;
			flash_ack  <= 1'b0;
			case (state)
				st_idle: begin
					if (rd_req) begin
						cmd   <= '{job: flash_pkg::job_read, addr: rd_addr};
						phase <= flash_pkg::ph_main;
						state <= st_open;
					end else if (pp_req) begin
						cmd   <= '{job: flash_pkg::job_pp, addr: wr_addr};
						phase <= flash_pkg::ph_wren;
						state <= st_open;
					end else if (se_req) begin
						cmd   <= '{job: flash_pkg::job_se, addr: se_addr};
						phase <= flash_pkg::ph_wren;
						state <= st_open;
					end
				end
				st_open: begin
					cs_n       <= 1'b0;
					byte_start <= 1'b1;
					state      <= st_xfer;
				end
				st_xfer: begin
					if (byte_done) begin
						state <= st_next; // byte_idx and status settle here
					end
				end
				st_next: begin
					case (phase)
						flash_pkg::ph_wren: begin
							cs_n      <= 1'b1;
							gap_start <= 1'b1;
							phase     <= flash_pkg::ph_main;
							state     <= st_gap;
						end
						flash_pkg::ph_main: begin
							if (byte_idx == main_len) begin
								cs_n <= 1'b1;
								if (cmd.job == flash_pkg::job_read) begin
									state <= st_close;
								end else begin
									gap_start <= 1'b1;
									phase     <= flash_pkg::ph_poll;
									state     <= st_gap;
								end
							end else begin
								byte_start <= 1'b1;
								state      <= st_xfer;
							end
						end
						flash_pkg::ph_poll: begin
							// chip select stays low and RDSR keeps returning the status
							if (byte_idx >= 9'd2 && !status.wip) begin
								cs_n  <= 1'b1;
								state <= st_close;
							end else begin
								byte_start <= 1'b1;
								state      <= st_xfer;
							end
						end
						default: begin
							cs_n  <= 1'b1;
							state <= st_close;
						end
					endcase
				end
				st_gap: begin
					if (gap_done) begin
						cs_n       <= 1'b0;
						byte_start <= 1'b1;
						state      <= st_xfer;
					end
				end
				st_close: begin
					flash_ack <= 1'b1;
					phase     <= flash_pkg::ph_idle;
					state     <= st_ack;
				end
				default: begin
					state <= st_idle; // the host drops its request during the ack cycle
				end
			endcase
		end
	end

endmodule

/* logic/flash_tx_mux.sv */
`timescale 1ns/1ps

module flash_tx_mux (
	input  flash_pkg::flash_cmd_t   cmd,
	input  flash_pkg::flash_phase_e phase,
	input  logic [8:0]              byte_idx,
	input  logic [7:0]              wr_data,
	output logic [7:0]              tx_byte
);

	logic [7:0] opcode;

	always_comb begin
		case (cmd.job)
			flash_pkg::job_read: opcode = flash_pkg::op_read;
			flash_pkg::job_pp:   opcode = flash_pkg::op_pp;
			flash_pkg::job_se:   opcode = flash_pkg::op_se;
			default:             opcode = 8'h00;
		endcase
	end

	always_comb begin
		tx_byte = 8'h00;
		case (phase)
			flash_pkg::ph_wren: begin
				tx_byte = flash_pkg::op_wren;
			end
			flash_pkg::ph_poll: begin
				if (byte_idx == 9'd0) begin
					tx_byte = flash_pkg::op_rdsr;
				end
			end
			flash_pkg::ph_main: begin
				case (byte_idx)
					9'd0:    tx_byte = opcode;
					9'd1:    tx_byte = cmd.addr[23:16];
					9'd2:    tx_byte = cmd.addr[15:8];
					9'd3:    tx_byte = cmd.addr[7:0];
					default: begin
						if (cmd.job == flash_pkg::job_pp) begin
							tx_byte = wr_data;
						end
					end
				endcase
			end
			default: begin
				tx_byte = 8'h00;
			end
		endcase
	end

endmodule

/* logic/spi_byte_shifter.sv */
`timescale 1ns/1ps

module spi_byte_shifter (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       byte_start,
	input  logic [7:0] tx_byte,
	input  logic       miso,
	output logic       byte_done,
	output logic [7:0] rx_byte,
	output logic       sclk,
	output logic       mosi
);

	logic       busy;
	logic [3:0] cnt;     // two clk cycles per sclk period
	logic [7:0] tx_sh;
	logic [7:0] rx_sh;

	assign rx_byte = rx_sh;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy      <= 1'b0;
			cnt       <= '0;
			sclk      <= 1'b0;
			mosi      <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (byte_start) begin
					busy <= 1'b1;
					cnt  <= '0;
					mosi <= tx_byte[7]; // MSB is set up ahead of the first rising edge
				end
			end else begin
				cnt <= cnt + 4'd1;
				if (!cnt[0]) begin
					sclk <= 1'b1;
				end else begin
					sclk <= 1'b0;
					mosi <= tx_sh[7];
					if (cnt == 4'd15) begin
						busy      <= 1'b0;
						byte_done <= 1'b1;
					end
				end
			end
		end
	end

	// miso is sampled as sclk rises and mosi moves on as sclk falls
	always_ff @(posedge clk) begin
		if (!busy && byte_start) begin
			tx_sh <= {tx_byte[6:0], 1'b0};
		end else if (busy && cnt[0]) begin
			tx_sh <= {tx_sh[6:0], 1'b0};
		end
		if (busy && !cnt[0]) begin
			rx_sh <= {rx_sh[6:0], miso};
		end
	end

endmodule
